// File: flist.f
source/rsa_pkg.sv
source/rsa_prescale.sv
source/rsa_mont.sv
source/rsa_exp.sv
source/rsa_top.sv
verification/tb_rsa.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the RSA engine testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_rsa -f flist.f -o tb_rsa_sim 2>&1 | tee sim.log

./obj_dir/tb_rsa_sim 2>&1 | tee -a sim.log

if grep -q "Verification failed" sim.log; then
	echo "run.sh: simulation reported errors, see sim.log"
	exit 1
fi

echo "run.sh: simulation finished, see sim.log"
exit 0

// File: source/rsa_exp.sv
`timescale 1ns/1ps
`default_nettype none

module rsa_exp (
	input  wire                i_clk,
	input  wire                i_rst,
	input  wire                i_start,
	input  wire rsa_pkg::key_t i_a,
	input  wire rsa_pkg::key_t i_d,
	input  wire rsa_pkg::key_t i_n,
	output logic               o_done,
	output rsa_pkg::key_t      o_result
);

	logic [rsa_pkg::state_w-1:0]   state;
	logic [rsa_pkg::bit_cnt_w-1:0] bit_idx;

	// m holds the plain result, t the running power in Montgomery form
	rsa_pkg::key_t m;
	rsa_pkg::key_t t;

	logic          pre_start;
	logic          pre_done;
	rsa_pkg::key_t pre_result;

	logic          mont_start;
	logic          mul_done;
	logic          sqr_done;
	rsa_pkg::key_t mul_result;
	rsa_pkg::key_t sqr_result;

	rsa_prescale u_prescale (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_start  (pre_start),
		.i_x      (i_a),
		.i_n      (i_n),
		.o_done   (pre_done),
		.o_result (pre_result)
	);

	// m * t
	rsa_mont u_mul (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_start  (mont_start),
		.i_x      (m),
		.i_y      (t),
		.i_n      (i_n),
		.o_done   (mul_done),
		.o_result (mul_result)
	);

	// t * t
	rsa_mont u_sqr (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_start  (mont_start),
		.i_x      (t),
		.i_y      (t),
		.i_n      (i_n),
		.o_done   (sqr_done),
		.o_result (sqr_result)
	);

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			state <= rsa_pkg::st_idle;
			bit_idx <= '0;
			pre_start <= 1'b0;
			mont_start <= 1'b0;
			o_done <= 1'b0;
		end else begin
			pre_start <= 1'b0;
			mont_start <= 1'b0;
			o_done <= 1'b0;
			case (state)
				rsa_pkg::st_idle: begin
					if (i_start) begin
						pre_start <= 1'b1;
						state <= rsa_pkg::st_prep;
					end
				end
				rsa_pkg::st_prep: begin
					if (pre_done) begin
						bit_idx <= '0;
						mont_start <= 1'b1;
						state <= rsa_pkg::st_mult;
					end
				end
				rsa_pkg::st_mult: begin
					if (mul_done && sqr_done) begin
						state <= rsa_pkg::st_update;
					end
				end
				rsa_pkg::st_update: begin
					if (bit_idx == rsa_pkg::bit_last) begin
						o_done <= 1'b1;
						state <= rsa_pkg::st_idle;
					end else begin
						bit_idx <= bit_idx + 1'b1;
						mont_start <= 1'b1;
						state <= rsa_pkg::st_mult;
					end
				end
				default: state <= rsa_pkg::st_idle;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (state == rsa_pkg::st_prep && pre_done) begin
			m <= {{(rsa_pkg::key_w-1){1'b0}}, 1'b1};
			t <= pre_result;
		end else if (state == rsa_pkg::st_update) begin
			if (i_d[bit_idx]) begin
				m <= mul_result;
			end
			t <= sqr_result;
		end
	end

	assign o_result = m;

endmodule

`default_nettype wire

// File: source/rsa_mont.sv
`timescale 1ns/1ps
`default_nettype none

module rsa_mont (
	input  wire                i_clk,
	input  wire                i_rst,
	input  wire                i_start,
	input  wire rsa_pkg::key_t i_x,
	input  wire rsa_pkg::key_t i_y,
	input  wire rsa_pkg::key_t i_n,
	output logic               o_done,
	output rsa_pkg::key_t      o_result
);

	logic                           busy;
	logic                           fin;
	logic [rsa_pkg::bit_cnt_w-1:0] cnt;
	logic [rsa_pkg::ext_w-1:0]     acc;
	logic [rsa_pkg::ext_w-1:0]     acc_sub;
	logic [rsa_pkg::ext_w:0]       sum_y;
	logic [rsa_pkg::ext_w:0]       sum_n;

	// add y when the current bit of x is set
	assign sum_y = {1'b0, acc} + (i_x[cnt] ? {2'b00, i_y} : '0);

	// make the sum even before halving
	assign sum_n = sum_y[0] ? (sum_y + {2'b00, i_n}) : sum_y;

	assign acc_sub = acc - {1'b0, i_n};

	// busy covers the 256 steps plus the subtract cycle
	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			busy <= 1'b0;
			fin <= 1'b0;
			cnt <= '0;
			o_done <= 1'b0;
		end else begin
			o_done <= 1'b0;
			if (i_start) begin
				busy <= 1'b1;
				fin <= 1'b0;
				cnt <= '0;
			end else if (busy) begin
				if (fin) begin
					busy <= 1'b0;
					fin <= 1'b0;
					o_done <= 1'b1;
				end else begin
					if (cnt == rsa_pkg::bit_last) begin
						fin <= 1'b1;
					end
					cnt <= cnt + 1'b1;
				end
			end
		end
	end

	// acc < 2n throughout, so one subtract gives the reduced product
	always_ff @(posedge i_clk) begin
		if (i_start) begin
			acc <= '0;
		end else if (busy) begin
			if (fin) begin
				if (acc >= {1'b0, i_n}) begin
					acc <= acc_sub;
				end
			end else begin
				acc <= sum_n[rsa_pkg::ext_w:1];
			end
		end
	end

	assign o_result = acc[rsa_pkg::key_w-1:0];

	// sequencer must wait for done before restarting
	a_no_restart: assert property (@(posedge i_clk) disable iff (i_rst)
		i_start |-> !busy);

endmodule

`default_nettype wire

// File: source/rsa_pkg.sv
`default_nettype none

package rsa_pkg;

	// operand width and working width with carry
	localparam int key_w = 256;
	localparam int ext_w = key_w + 1;

	// counter widths
	localparam int bit_cnt_w = 8;
	localparam int prep_cnt_w = 9;

	typedef logic [key_w-1:0] key_t;

	// last exponent / multiplier bit, and last pre-scale step
	localparam logic [bit_cnt_w-1:0] bit_last = bit_cnt_w'(key_w - 1);
	localparam logic [prep_cnt_w-1:0] prep_last = prep_cnt_w'(key_w);

	// sequencer states
	localparam int state_w = 2;
	localparam logic [state_w-1:0] st_idle = 2'd0;
	localparam logic [state_w-1:0] st_prep = 2'd1;
	localparam logic [state_w-1:0] st_mult = 2'd2;
	localparam logic [state_w-1:0] st_update = 2'd3;

	localparam key_t res_rst_val = '0;

endpackage

`default_nettype wire

// File: source/rsa_prescale.sv
`timescale 1ns/1ps
`default_nettype none

module rsa_prescale (
	input  wire                i_clk,
	input  wire                i_rst,
	input  wire                i_start,
	input  wire rsa_pkg::key_t i_x,
	input  wire rsa_pkg::key_t i_n,
	output logic               o_done,
	output rsa_pkg::key_t      o_result
);

	logic                            busy;
	logic [rsa_pkg::prep_cnt_w-1:0] cnt;
	logic [rsa_pkg::ext_w-1:0]      acc;
	logic [rsa_pkg::ext_w-1:0]      acc_nxt;
	logic [rsa_pkg::ext_w-1:0]      acc_sub;
	logic [rsa_pkg::ext_w:0]        dbl;
	logic [rsa_pkg::ext_w:0]        dbl_sub;

	assign dbl = {acc, 1'b0};
	assign dbl_sub = dbl - {2'b00, i_n};
	assign acc_sub = acc - {1'b0, i_n};

	// acc stays below n, so one subtract per doubling is enough
	always_comb begin
		if (cnt == rsa_pkg::prep_last) begin
			// final reduce only
			acc_nxt = (acc >= {1'b0, i_n}) ? acc_sub : acc;
		end else if (dbl >= {2'b00, i_n}) begin
			acc_nxt = dbl_sub[rsa_pkg::ext_w-1:0];
		end else begin
			acc_nxt = dbl[rsa_pkg::ext_w-1:0];
		end
	end

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			busy <= 1'b0;
			cnt <= '0;
			o_done <= 1'b0;
		end else begin
			o_done <= 1'b0;
			if (i_start) begin
				busy <= 1'b1;
				cnt <= '0;
			end else if (busy) begin
				if (cnt == rsa_pkg::prep_last) begin
					busy <= 1'b0;
					o_done <= 1'b1;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_start) begin
			acc <= {1'b0, i_x};
		end else if (busy) begin
			acc <= acc_nxt;
		end
	end

	assign o_result = acc[rsa_pkg::key_w-1:0];

	// operand must come out in [0, n)
	a_result_reduced: assert property (@(posedge i_clk) disable iff (i_rst)
		o_done |-> (o_result < i_n));

endmodule

`default_nettype wire

// File: source/rsa_top.sv
`timescale 1ns/1ps
`default_nettype none

module rsa_top (
	input  wire                i_clk,
	input  wire                i_rst,
	input  wire                i_req_valid,
	output logic               o_req_ready,
	input  wire rsa_pkg::key_t i_a,
	input  wire rsa_pkg::key_t i_d,
	input  wire rsa_pkg::key_t i_n,
	output logic               o_res_valid,
	input  wire                i_res_ready,
	output rsa_pkg::key_t      o_res
);

	// operand latches
	rsa_pkg::key_t a_q;
	rsa_pkg::key_t d_q;
	rsa_pkg::key_t n_q;

	logic          busy;
	logic          req_fire;
	logic          exp_start;
	logic          exp_done;
	rsa_pkg::key_t exp_result;

	// no new request while running or while a result waits
	assign o_req_ready = !busy && !o_res_valid;
	assign req_fire = i_req_valid && o_req_ready;

	always_ff @(posedge i_clk) begin
		if (req_fire) begin
			a_q <= i_a;
			d_q <= i_d;
			n_q <= i_n;
		end
	end

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			busy <= 1'b0;
			exp_start <= 1'b0;
			o_res_valid <= 1'b0;
			o_res <= rsa_pkg::res_rst_val;
		end else begin
			// start goes out the cycle after the operands are latched
			exp_start <= req_fire;

			if (req_fire) begin
				busy <= 1'b1;
			end else if (exp_done) begin
				busy <= 1'b0;
			end

			if (exp_done) begin
				o_res_valid <= 1'b1;
				o_res <= exp_result;
			end else if (o_res_valid && i_res_ready) begin
				o_res_valid <= 1'b0;
			end
		end
	end

	rsa_exp u_exp (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_start  (exp_start),
		.i_a      (a_q),
		.i_d      (d_q),
		.i_n      (n_q),
		.o_done   (exp_done),
		.o_result (exp_result)
	);

	// result held under back-pressure
	a_res_hold: assert property (@(posedge i_clk) disable iff (i_rst)
		(o_res_valid && !i_res_ready) |=> (o_res_valid && $stable(o_res)));

	// engine only finishes a run that was started from here
	a_done_when_busy: assert property (@(posedge i_clk) disable iff (i_rst)
		exp_done |-> busy);

endmodule

`default_nettype wire

// File: verification/tb_rsa.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rsa;

	localparam int timeout_cycles = 80000;

	logic          i_clk;
	logic          i_rst;
	logic          i_req_valid;
	logic          o_req_ready;
	rsa_pkg::key_t i_a;
	rsa_pkg::key_t i_d;
	rsa_pkg::key_t i_n;
	logic          o_res_valid;
	logic          i_res_ready;
	rsa_pkg::key_t o_res;

	int          check_cnt = 0;
	int          err_cnt = 0;
	int          timeout_cnt = 0;
	logic [31:0] lfsr_state = 32'h1f3d;

	rsa_top uut (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_req_valid (i_req_valid),
		.o_req_ready (o_req_ready),
		.i_a         (i_a),
		.i_d         (i_d),
		.i_n         (i_n),
		.o_res_valid (o_res_valid),
		.i_res_ready (i_res_ready),
		.o_res       (o_res)
	);

	initial begin
		i_clk = 1'b0;
		forever #2 i_clk = ~i_clk;
	end

	// inputs change 1 ns after the edge
	task automatic next_cycle();
		@(posedge i_clk);
		#1;
	endtask

	task automatic apply_reset();
		i_rst = 1'b1;
		i_req_valid = 1'b0;
		repeat (2) next_cycle();
		i_rst = 1'b0;
	endtask

	// galois form, taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic [31:0] r;
		r = s >> 1;
		if (s[0]) begin
			r = r ^ 32'h8020_0003;
		end
		return r;
	endfunction

	task automatic draw_key(output rsa_pkg::key_t k);
		for (int i = 0; i < rsa_pkg::key_w; i++) begin
			k[i] = lfsr_state[0];
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// odd modulus, base reduced below it
	task automatic draw_operands(output rsa_pkg::key_t a, output rsa_pkg::key_t n);
		rsa_pkg::key_t raw;
		draw_key(n);
		n[0] = 1'b1;
		draw_key(raw);
		a = raw % n;
	endtask

	// square-and-multiply from bit 0, plain integer arithmetic
	function automatic rsa_pkg::key_t model_modexp(input rsa_pkg::key_t a,
		input rsa_pkg::key_t d, input rsa_pkg::key_t n);
		logic [511:0] nn;
		logic [511:0] base;
		logic [511:0] res;
		nn = {256'd0, n};
		base = {256'd0, a} % nn;
		res = 512'd1 % nn;
		for (int i = 0; i < rsa_pkg::key_w; i++) begin
			if (d[i]) begin
				res = (res * base) % nn;
			end
			base = (base * base) % nn;
		end
		return res[255:0];
	endfunction

	task automatic check_key(input string name, input rsa_pkg::key_t got,
		input rsa_pkg::key_t exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	// holds valid until the handshake edge
	task automatic send_req(input rsa_pkg::key_t a, input rsa_pkg::key_t d,
		input rsa_pkg::key_t n);
		int cnt;
		cnt = 0;
		i_a = a;
		i_d = d;
		i_n = n;
		i_req_valid = 1'b1;
		while (o_req_ready !== 1'b1 && cnt < timeout_cycles) begin
			next_cycle();
			cnt++;
		end
		if (o_req_ready !== 1'b1) begin
			timeout_cnt++;
			$display("timeout: request not accepted within %0d cycles", timeout_cycles);
		end
		next_cycle();
		i_req_valid = 1'b0;
	endtask

	task automatic wait_result(output rsa_pkg::key_t res, output logic ok);
		int cnt;
		cnt = 0;
		while (o_res_valid !== 1'b1 && cnt < timeout_cycles) begin
			next_cycle();
			cnt++;
		end
		ok = (o_res_valid === 1'b1);
		res = o_res;
		if (!ok) begin
			timeout_cnt++;
			$display("timeout: no result within %0d cycles", timeout_cycles);
		end
	endtask

	task automatic run_case(input string label, input rsa_pkg::key_t a,
		input rsa_pkg::key_t d, input rsa_pkg::key_t n, input rsa_pkg::key_t exp);
		rsa_pkg::key_t res;
		logic          ok;
		$display("case: %s", label);
		i_res_ready = 1'b1;
		send_req(a, d, n);
		wait_result(res, ok);
		if (ok) begin
			check_key("o_res", res, exp);
			next_cycle();
		end
	endtask

	task automatic after_reset_outputs();
		check_bit("o_res_valid", o_res_valid, 1'b0);
		check_bit("o_req_ready", o_req_ready, 1'b1);
		check_key("o_res", o_res, '0);
	endtask

	task automatic small_known_cases();
		run_case("5^3 mod 23", 256'd5, 256'd3, 256'd23, 256'd10);
		run_case("5^0 mod 23", 256'd5, 256'd0, 256'd23, 256'd1);
	endtask

	task automatic identity_exponent();
		rsa_pkg::key_t a;
		rsa_pkg::key_t n;
		draw_operands(a, n);
		run_case("d = 1", a, 256'd1, n, a);
	endtask

	task automatic random_operands();
		rsa_pkg::key_t a;
		rsa_pkg::key_t d;
		rsa_pkg::key_t n;
		for (int i = 0; i < 3; i++) begin
			draw_operands(a, n);
			draw_key(d);
			run_case("random", a, d, n, model_modexp(a, d, n));
		end
	endtask

	task automatic back_pressure();
		rsa_pkg::key_t a;
		rsa_pkg::key_t d;
		rsa_pkg::key_t n;
		rsa_pkg::key_t a2;
		rsa_pkg::key_t d2;
		rsa_pkg::key_t n2;
		rsa_pkg::key_t held;
		logic          ok;
		$display("case: back-pressure");
		draw_operands(a, n);
		draw_key(d);
		draw_operands(a2, n2);
		draw_key(d2);
		i_res_ready = 1'b0;
		send_req(a, d, n);
		wait_result(held, ok);
		if (ok) begin
			check_key("o_res", held, model_modexp(a, d, n));
			// second request is offered while the result waits
			i_a = a2;
			i_d = d2;
			i_n = n2;
			i_req_valid = 1'b1;
			repeat (50) begin
				next_cycle();
				check_key("o_res", o_res, held);
				check_bit("o_res_valid", o_res_valid, 1'b1);
				check_bit("o_req_ready", o_req_ready, 1'b0);
			end
			i_res_ready = 1'b1;
			next_cycle();
			check_bit("o_res_valid", o_res_valid, 1'b0);
			run_case("after back-pressure", a2, d2, n2, model_modexp(a2, d2, n2));
		end
		i_res_ready = 1'b1;
	endtask

	task automatic reset_mid_run();
		rsa_pkg::key_t a;
		rsa_pkg::key_t d;
		rsa_pkg::key_t n;
		$display("case: reset during a run");
		draw_operands(a, n);
		draw_key(d);
		i_res_ready = 1'b1;
		send_req(a, d, n);
		repeat (1000) next_cycle();
		apply_reset();
		after_reset_outputs();
		draw_operands(a, n);
		draw_key(d);
		run_case("after reset", a, d, n, model_modexp(a, d, n));
	endtask

	initial begin
		i_rst = 1'b1;
		i_req_valid = 1'b0;
		i_a = '0;
		i_d = '0;
		i_n = '0;
		i_res_ready = 1'b0;
		apply_reset();

		after_reset_outputs();
		small_known_cases();
		identity_exponent();
		random_operands();
		back_pressure();
		reset_mid_run();

		$display("checks: %0d, value errors: %0d, timeouts: %0d",
			check_cnt, err_cnt, timeout_cnt);
		if (err_cnt == 0 && timeout_cnt == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
